// ==== bench/rv_mem_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_mem_defines.svh"

module rv_mem_properties (
    input  wire logic               clk,
    input  wire logic               resetn_i,
    input  wire logic               mem_read_i,
    input  wire logic               mem_write_i,
    input  wire logic [`XLEN-1:0]   mem_addr_i,
    input  wire logic [`XLEN-1:0]   mem_wdata_i,
    input  wire logic [1:0]         mem_size_i,
    input  wire logic               mem_valid_i,
    input  wire logic               ex_get_i,
    input  wire logic               wb_give_i
);

    int unsigned assert_fails = 0;   // Read by the testbench monitor

    a_one_direction: assert property (@(posedge clk) disable iff (!resetn_i)
        !(mem_read_i && mem_write_i))
        else begin
            assert_fails++;
            $error("memory read and write requested in the same cycle");
        end

    // Request fields frozen until the memory answers
    a_req_stable: assert property (@(posedge clk) disable iff (!resetn_i)
        (mem_read_i || mem_write_i) && !mem_valid_i |=>
            $stable(mem_addr_i) && $stable(mem_wdata_i) && $stable(mem_size_i) &&
            $stable(mem_read_i) && $stable(mem_write_i))
        else begin
            assert_fails++;
            $error("memory request changed before valid");
        end

    a_one_side: assert property (@(posedge clk) disable iff (!resetn_i)
        !(ex_get_i && wb_give_i))
        else begin
            assert_fails++;
            $error("ex_get_o and wb_give_o high together");
        end

endmodule

bind rv_mem_stage rv_mem_properties u_props (
    .clk         (clk),
    .resetn_i    (resetn_i),
    .mem_read_i  (mem_read_o),
    .mem_write_i (mem_write_o),
    .mem_addr_i  (mem_addr_o),
    .mem_wdata_i (mem_wdata_o),
    .mem_size_i  (mem_size_o),
    .mem_valid_i (mem_valid_i),
    .ex_get_i    (ex_get_o),
    .wb_give_i   (wb_give_o)
);

`default_nettype wire

// ==== bench/rv_mem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_mem_defines.svh"

module rv_mem_tb
    import rv_mem_pkg::*;
();

    localparam int N_INSTR        = 400;
    localparam int WIN_WORDS      = 32;    // Words the stream touches
    localparam int RESET_CYCLES   = 8;
    localparam int IDX_W          = $clog2(`RAM_DEPTH_WORDS);
    localparam int TIMEOUT_CYCLES = N_INSTR * (`RAM_WAIT_CYCLES + 20) + RESET_CYCLES;

    logic               clk = 1'b0;
    logic               resetn_i;
    logic               ex_give_i;
    logic               ex_get_o;
    logic [31:0]        ex_instr_i;
    logic [`XLEN-1:0]   ex_result_i;
    logic [`XLEN-1:0]   ex_rs2_i;
    logic               wb_get_i;
    logic               wb_give_o;
    logic [31:0]        wb_instr_o;
    logic [`XLEN-1:0]   wb_data_o;

    integer             seed = 18388;
    int                 next_idx;
    int                 done_cnt;
    int                 pend_q [$];          // Accepted, not yet written back
    logic [31:0]        instr_arr  [N_INSTR];
    logic [31:0]        result_arr [N_INSTR];
    logic [31:0]        rs2_arr    [N_INSTR];
    logic [31:0]        model_mem  [`RAM_DEPTH_WORDS];

    rv_mem_subsys UUT (
        .clk         (clk),
        .resetn_i    (resetn_i),
        .ex_give_i   (ex_give_i),
        .ex_get_o    (ex_get_o),
        .ex_instr_i  (ex_instr_i),
        .ex_result_i (ex_result_i),
        .ex_rs2_i    (ex_rs2_i),
        .wb_get_i    (wb_get_i),
        .wb_give_o   (wb_give_o),
        .wb_instr_o  (wb_instr_o),
        .wb_data_o   (wb_data_o)
    );

    always #2 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("ERROR: %s is 0x%08h, expected 0x%08h", name, actual, expected));
        end
    endtask

    function automatic logic [31:0] mem_instr(input logic [6:0] op, input logic [2:0] f3);
        logic [31:0] w;
        w = $random(seed);
        w[14:12] = f3;
        w[6:0] = op;
        return w;
    endfunction

    // Odd stride scatters the window words over the whole memory
    function automatic logic [31:0] window_addr(input int w, input logic [1:0] lane);
        return 32'((w * 37) % `RAM_DEPTH_WORDS) * 32'd4 + 32'(lane);
    endfunction

    task automatic build_stream();
        logic [31:0] r;
        logic [2:0]  f3;
        logic [6:0]  op;
        // Word store then word load for every word of the window
        for (int i = 0; i < WIN_WORDS; i++) begin
            r = $random(seed);
            instr_arr[2*i]    = mem_instr(`OP_STORE, 3'b010);
            result_arr[2*i]   = window_addr(i, r[1:0]);
            rs2_arr[2*i]      = $random(seed);
            instr_arr[2*i+1]  = mem_instr(`OP_LOAD, 3'b010);
            result_arr[2*i+1] = window_addr(i, 2'b00);
            rs2_arr[2*i+1]    = $random(seed);
        end
        for (int i = 2 * WIN_WORDS; i < N_INSTR; i++) begin
            r = $random(seed);
            f3 = {1'b0, r[9:8] % 2'd3};
            rs2_arr[i] = $random(seed);
            result_arr[i] = $random(seed);
            if (r[2:0] < 3'd6) begin
                result_arr[i] = window_addr(int'(result_arr[i][31:2] % WIN_WORDS),
                                            result_arr[i][1:0]);
            end
            case (r[2:0])
                3'd0, 3'd1, 3'd2: begin
                    if (f3[1:0] != 2'b10) begin
                        f3[2] = r[12];   // LBU / LHU
                    end
                    instr_arr[i] = mem_instr(`OP_LOAD, f3);
                end
                3'd3, 3'd4, 3'd5: instr_arr[i] = mem_instr(`OP_STORE, f3);
                default: begin
                    op = r[22:16];
                    if (op == `OP_LOAD || op == `OP_STORE) begin
                        op = 7'b0110011;
                    end
                    instr_arr[i] = mem_instr(op, r[15:13]);
                end
            endcase
        end
    endtask

    // Reference model, one call per write-back in program order
    task automatic expected_data(input int idx, output logic [31:0] exp_data);
        logic [31:0]      word;
        logic [31:0]      addr;
        logic [IDX_W-1:0] widx;
        access_size_e     sz;
        addr = result_arr[idx];
        widx = addr[IDX_W+1:2];
        word = model_mem[widx];
        sz = access_size_e'(instr_arr[idx][13:12]);
        exp_data = result_arr[idx];
        if (instr_arr[idx][6:0] == `OP_LOAD) begin
            case (sz)
                SZ_BYTE: begin
                    exp_data = (word >> {addr[1:0], 3'b000}) & 32'hff;
                    if (!instr_arr[idx][14] && exp_data[7]) begin
                        exp_data = exp_data | 32'hffffff00;
                    end
                end
                SZ_HALF: begin
                    exp_data = (word >> {addr[1], 4'b0000}) & 32'hffff;
                    if (!instr_arr[idx][14] && exp_data[15]) begin
                        exp_data = exp_data | 32'hffff0000;
                    end
                end
                default: exp_data = word;
            endcase
        end else if (instr_arr[idx][6:0] == `OP_STORE) begin
            case (sz)
                SZ_BYTE: word[{addr[1:0], 3'b000} +: 8] = rs2_arr[idx][7:0];
                SZ_HALF: word[{addr[1], 4'b0000} +: 16] = rs2_arr[idx][15:0];
                default: word = rs2_arr[idx];
            endcase
            model_mem[widx] = word;
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        r = $random(seed);
        if (next_idx < N_INSTR && r[1:0] != 2'b00) begin
            ex_give_i   = 1'b1;
            ex_instr_i  = instr_arr[next_idx];
            ex_result_i = result_arr[next_idx];
            ex_rs2_i    = rs2_arr[next_idx];
        end else begin
            ex_give_i = 1'b0;
        end
        wb_get_i = (r[5:4] != 2'b00);   // Random write-back stalls
    endtask

    task automatic sample_outputs();
        logic [31:0] exp_data;
        int          idx;
        if (UUT.u_stage.u_props.assert_fails != 0) begin
            fail_run("a handshake assertion on the MEM stage failed");
        end
        check_value("ex_get_o", 32'(ex_get_o), 32'(pend_q.size() == 0));
        if (wb_give_o) begin
            if (pend_q.size() == 0) begin
                fail_run("write-back was offered an item that was never accepted");
            end else begin
                idx = pend_q.pop_front();
                expected_data(idx, exp_data);
                check_value("wb_instr_o", wb_instr_o, instr_arr[idx]);
                check_value("wb_data_o", wb_data_o, exp_data);
                done_cnt++;
            end
        end
        if (ex_give_i && ex_get_o) begin
            pend_q.push_back(next_idx);
            next_idx++;
        end
    endtask

    initial begin
        resetn_i    = 1'b0;
        ex_give_i   = 1'b0;
        ex_instr_i  = '0;
        ex_result_i = '0;
        ex_rs2_i    = '0;
        wb_get_i    = 1'b0;
        next_idx    = 0;
        done_cnt    = 0;
        build_stream();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        resetn_i = 1'b1;
        #1;
        check_value("ex_get_o", 32'(ex_get_o), 32'h1);
        check_value("wb_give_o", 32'(wb_give_o), 32'h0);
        check_value("mem_read", 32'(UUT.mem_read), 32'h0);
        check_value("mem_write", 32'(UUT.mem_write), 32'h0);
        while (done_cnt < N_INSTR) begin
            @(negedge clk);
            drive_inputs();
            #1;
            sample_outputs();
        end
        // A few idle cycles, nothing more may come out
        repeat (4) begin
            @(negedge clk);
            ex_give_i = 1'b0;
            wb_get_i  = 1'b1;
            #1;
            sample_outputs();
        end
        $display("All checks passed");
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        fail_run($sformatf("timeout with %0d of %0d instructions written back",
                           done_cnt, N_INSTR));
    end

endmodule

`default_nettype wire

// ==== hdl/rv_data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_mem_defines.svh"

module rv_data_ram
    import rv_mem_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               resetn_i,
    input  wire logic [`XLEN-1:0]   addr_i,
    input  wire logic [`XLEN-1:0]   wdata_i,
    input  wire access_size_e       size_i,
    input  wire logic               read_i,
    input  wire logic               write_i,
    output logic [`XLEN-1:0]        rdata_o,
    output logic                    valid_o
);

    localparam int IDX_W = $clog2(`RAM_DEPTH_WORDS);
    localparam int CNT_W = $clog2(`RAM_WAIT_CYCLES + 2);

    mem_word_u         mem_q [`RAM_DEPTH_WORDS];

    logic [IDX_W-1:0]  idx;
    logic [CNT_W-1:0]  cnt_q;
    logic              valid_q;
    logic [`XLEN-1:0]  rdata_q;
    logic              req;
    mem_word_u         cur_word;
    mem_word_u         wr_word;
    logic [`XLEN-1:0]  rd_lane;

    assign idx      = addr_i[IDX_W+1:2];   // Low bits pick the lane only
    assign req      = read_i || write_i;
    assign cur_word = mem_q[idx];

    // Store merge, only the addressed lane changes
    always_comb begin
        wr_word = cur_word;
        case (size_i)
            SZ_BYTE: wr_word.byte_lane[addr_i[1:0]] = wdata_i[7:0];
            SZ_HALF: wr_word.half_lane[addr_i[1]]   = wdata_i[15:0];
            default: wr_word = wdata_i;
        endcase
    end

    // Load lane, zero-filled above
    always_comb begin
        case (size_i)
            SZ_BYTE: rd_lane = {{(`XLEN-8){1'b0}}, cur_word.byte_lane[addr_i[1:0]]};
            SZ_HALF: rd_lane = {{(`XLEN-16){1'b0}}, cur_word.half_lane[addr_i[1]]};
            default: rd_lane = cur_word;
        endcase
    end

    // Wait-state counter, valid is a single-cycle pulse
    always_ff @(posedge clk) begin
        if (!resetn_i) begin
            cnt_q   <= '0;
            valid_q <= 1'b0;
        end else if (!req || valid_q) begin
            cnt_q   <= '0;
            valid_q <= 1'b0;
        end else if (cnt_q == CNT_W'(`RAM_WAIT_CYCLES)) begin
            valid_q <= 1'b1;
        end else begin
            cnt_q   <= cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (req && !valid_q && cnt_q == CNT_W'(`RAM_WAIT_CYCLES)) begin
            rdata_q <= rd_lane;
        end
        if (write_i && valid_q) begin
            mem_q[idx] <= wr_word;   // Commits on the valid edge
        end
    end

    assign rdata_o = rdata_q;
    assign valid_o = valid_q;

endmodule

`default_nettype wire

// ==== hdl/rv_mem_defines.svh ====
`ifndef RV_MEM_DEFINES_SVH
`define RV_MEM_DEFINES_SVH

// Data and address width
`define XLEN 32

// Data memory size in 32-bit words
`define RAM_DEPTH_WORDS 256

// Extra cycles before the memory answers
`define RAM_WAIT_CYCLES 2

// RV32I major opcodes
`define OP_LOAD  7'b0000011
`define OP_STORE 7'b0100011

// funct3 fields of a load or store
`define F3_SIZE_MSB 13
`define F3_SIZE_LSB 12
`define F3_UNSIGNED 14

`endif

// ==== hdl/rv_mem_pkg.sv ====
`default_nettype none

`include "rv_mem_defines.svh"

package rv_mem_pkg;

    // Access width, straight from funct3[13:12]
    typedef enum logic [1:0] {
        SZ_BYTE = 2'b00,
        SZ_HALF = 2'b01,
        SZ_WORD = 2'b10
    } access_size_e;

    localparam int BYTE_LANES = `XLEN / 8;
    localparam int HALF_LANES = `XLEN / 16;

    // One memory word, seen as byte lanes or as halfword lanes
    typedef union packed {
        logic [BYTE_LANES-1:0][7:0]  byte_lane;
        logic [HALF_LANES-1:0][15:0] half_lane;
    } mem_word_u;

endpackage

`default_nettype wire

// ==== hdl/rv_mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_mem_defines.svh"

module rv_mem_stage
    import rv_mem_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               resetn_i,
    // Execute side
    input  wire logic               ex_give_i,
    output logic                    ex_get_o,
    input  wire logic [31:0]        ex_instr_i,
    input  wire logic [`XLEN-1:0]   ex_result_i,
    input  wire logic [`XLEN-1:0]   ex_rs2_i,
    // Data memory
    output logic [`XLEN-1:0]        mem_addr_o,
    output logic [`XLEN-1:0]        mem_wdata_o,
    output access_size_e            mem_size_o,
    output logic                    mem_read_o,
    output logic                    mem_write_o,
    input  wire logic [`XLEN-1:0]   mem_rdata_i,
    input  wire logic               mem_valid_i,
    // Write-back side
    input  wire logic               wb_get_i,
    output logic                    wb_give_o,
    output logic [31:0]             wb_instr_o,
    output logic [`XLEN-1:0]        wb_data_o
);

    enum logic [1:0] {IDLE, ACCESS, HANDOFF} state_q, state_d;

    logic [31:0]       instr_q;
    logic [`XLEN-1:0]  addr_q;
    logic [`XLEN-1:0]  data_q;     // rs2 while storing, result afterwards

    logic              ex_is_mem;
    logic              is_load;
    logic              is_store;
    logic              accept;
    logic              done;
    access_size_e      size;
    logic [`XLEN-1:0]  load_ext;

    assign ex_is_mem = (ex_instr_i[6:0] == `OP_LOAD) || (ex_instr_i[6:0] == `OP_STORE);
    assign is_load   = (instr_q[6:0] == `OP_LOAD);
    assign is_store  = (instr_q[6:0] == `OP_STORE);
    assign size      = access_size_e'(instr_q[`F3_SIZE_MSB:`F3_SIZE_LSB]);

    assign accept = ex_get_o && ex_give_i;
    assign done   = (state_q == ACCESS) && mem_valid_i;

    // Memory returns the lane in the low bits
    always_comb begin
        case (size)
            SZ_BYTE: load_ext = {{(`XLEN-8){~instr_q[`F3_UNSIGNED] & mem_rdata_i[7]}},
                                 mem_rdata_i[7:0]};
            SZ_HALF: load_ext = {{(`XLEN-16){~instr_q[`F3_UNSIGNED] & mem_rdata_i[15]}},
                                 mem_rdata_i[15:0]};
            default: load_ext = mem_rdata_i;
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (ex_give_i) begin
                    state_d = ex_is_mem ? ACCESS : HANDOFF;
                end
            end
            ACCESS: begin
                if (mem_valid_i) begin
                    state_d = HANDOFF;
                end
            end
            HANDOFF: begin
                if (wb_get_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            instr_q <= ex_instr_i;
            addr_q  <= ex_result_i;
            data_q  <= ex_is_mem ? ex_rs2_i : ex_result_i;
        end else if (done) begin
            data_q  <= is_load ? load_ext : addr_q;
        end
    end

    assign ex_get_o = (state_q == IDLE);

    // Request held steady for the whole ACCESS state
    assign mem_addr_o  = addr_q;
    assign mem_wdata_o = data_q;
    assign mem_size_o  = size;
    assign mem_read_o  = (state_q == ACCESS) && is_load;
    assign mem_write_o = (state_q == ACCESS) && is_store;

    assign wb_give_o  = (state_q == HANDOFF) && wb_get_i;
    assign wb_instr_o = instr_q;
    assign wb_data_o  = data_q;    // Load value or ALU result

endmodule

`default_nettype wire

// ==== hdl/rv_mem_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_mem_defines.svh"

module rv_mem_subsys
    import rv_mem_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               resetn_i,
    input  wire logic               ex_give_i,
    output logic                    ex_get_o,
    input  wire logic [31:0]        ex_instr_i,
    input  wire logic [`XLEN-1:0]   ex_result_i,
    input  wire logic [`XLEN-1:0]   ex_rs2_i,
    input  wire logic               wb_get_i,
    output logic                    wb_give_o,
    output logic [31:0]             wb_instr_o,
    output logic [`XLEN-1:0]        wb_data_o
);

    // Stage to memory request
    logic [`XLEN-1:0]  mem_addr;
    logic [`XLEN-1:0]  mem_wdata;
    access_size_e      mem_size;
    logic              mem_read;
    logic              mem_write;
    logic [`XLEN-1:0]  mem_rdata;
    logic              mem_valid;

    rv_mem_stage u_stage (
        .clk         (clk),
        .resetn_i    (resetn_i),
        .ex_give_i   (ex_give_i),
        .ex_get_o    (ex_get_o),
        .ex_instr_i  (ex_instr_i),
        .ex_result_i (ex_result_i),
        .ex_rs2_i    (ex_rs2_i),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_size_o  (mem_size),
        .mem_read_o  (mem_read),
        .mem_write_o (mem_write),
        .mem_rdata_i (mem_rdata),
        .mem_valid_i (mem_valid),
        .wb_get_i    (wb_get_i),
        .wb_give_o   (wb_give_o),
        .wb_instr_o  (wb_instr_o),
        .wb_data_o   (wb_data_o)
    );

    rv_data_ram u_ram (
        .clk      (clk),
        .resetn_i (resetn_i),
        .addr_i   (mem_addr),
        .wdata_i  (mem_wdata),
        .size_i   (mem_size),
        .read_i   (mem_read),
        .write_i  (mem_write),
        .rdata_o  (mem_rdata),
        .valid_o  (mem_valid)
    );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the MEM stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -f src.f --top-module rv_mem_tb -o rv_mem_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/rv_mem_sim +verilator+error+limit+100 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^All checks passed$"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== src.f ====
+incdir+hdl
hdl/rv_mem_pkg.sv
hdl/rv_mem_stage.sv
hdl/rv_data_ram.sv
hdl/rv_mem_subsys.sv
bench/rv_mem_properties.sv
bench/rv_mem_tb.sv
